//--- hdl/vid_pkg.sv
package vid_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and format codes
	////////////////////////////////////////////////////////////////////////////
	localparam int CNT_W = 11;  // h/v counter width
	localparam int FMT_W = 4;

	localparam logic [FMT_W-1:0] FMT_VGA     = 4'b0000;
	localparam logic [FMT_W-1:0] FMT_SVGA    = 4'b0001;
	localparam logic [FMT_W-1:0] FMT_XGA     = 4'b0011;
	localparam logic [FMT_W-1:0] FMT_HDTV720P = 4'b0010;  // Also the fallback
	localparam logic [FMT_W-1:0] FMT_SXGA    = 4'b1000;
	localparam logic [FMT_W-1:0] FMT_CAMERA  = 4'b1001;

	////////////////////////////////////////////////////////////////////////////
	// Per-format timing
	////////////////////////////////////////////////////////////////////////////
	// 640x480
	localparam logic [CNT_W-1:0] HPIXELS_VGA = 11'd640;
	localparam logic [CNT_W-1:0] HFNPRCH_VGA = 11'd16;
	localparam logic [CNT_W-1:0] HSYNCPW_VGA = 11'd96;
	localparam logic [CNT_W-1:0] HBKPRCH_VGA = 11'd48;
	localparam logic [CNT_W-1:0] VLINES_VGA  = 11'd480;
	localparam logic [CNT_W-1:0] VFNPRCH_VGA = 11'd11;
	localparam logic [CNT_W-1:0] VSYNCPW_VGA = 11'd2;
	localparam logic [CNT_W-1:0] VBKPRCH_VGA = 11'd31;

	// 800x600
	localparam logic [CNT_W-1:0] HPIXELS_SVGA = 11'd800;
	localparam logic [CNT_W-1:0] HFNPRCH_SVGA = 11'd40;
	localparam logic [CNT_W-1:0] HSYNCPW_SVGA = 11'd128;
	localparam logic [CNT_W-1:0] HBKPRCH_SVGA = 11'd88;
	localparam logic [CNT_W-1:0] VLINES_SVGA  = 11'd600;
	localparam logic [CNT_W-1:0] VFNPRCH_SVGA = 11'd1;
	localparam logic [CNT_W-1:0] VSYNCPW_SVGA = 11'd4;
	localparam logic [CNT_W-1:0] VBKPRCH_SVGA = 11'd23;

	// 1024x768
	localparam logic [CNT_W-1:0] HPIXELS_XGA = 11'd1024;
	localparam logic [CNT_W-1:0] HFNPRCH_XGA = 11'd24;
	localparam logic [CNT_W-1:0] HSYNCPW_XGA = 11'd136;
	localparam logic [CNT_W-1:0] HBKPRCH_XGA = 11'd160;
	localparam logic [CNT_W-1:0] VLINES_XGA  = 11'd768;
	localparam logic [CNT_W-1:0] VFNPRCH_XGA = 11'd3;
	localparam logic [CNT_W-1:0] VSYNCPW_XGA = 11'd6;
	localparam logic [CNT_W-1:0] VBKPRCH_XGA = 11'd29;

	// 1280x720 progressive
	localparam logic [CNT_W-1:0] HPIXELS_HDTV720P = 11'd1280;
	localparam logic [CNT_W-1:0] HFNPRCH_HDTV720P = 11'd110;
	localparam logic [CNT_W-1:0] HSYNCPW_HDTV720P = 11'd40;
	localparam logic [CNT_W-1:0] HBKPRCH_HDTV720P = 11'd220;
	localparam logic [CNT_W-1:0] VLINES_HDTV720P  = 11'd720;
	localparam logic [CNT_W-1:0] VFNPRCH_HDTV720P = 11'd5;
	localparam logic [CNT_W-1:0] VSYNCPW_HDTV720P = 11'd5;
	localparam logic [CNT_W-1:0] VBKPRCH_HDTV720P = 11'd20;

	// 1280x1024
	localparam logic [CNT_W-1:0] HPIXELS_SXGA = 11'd1280;
	localparam logic [CNT_W-1:0] HFNPRCH_SXGA = 11'd48;
	localparam logic [CNT_W-1:0] HSYNCPW_SXGA = 11'd112;
	localparam logic [CNT_W-1:0] HBKPRCH_SXGA = 11'd248;
	localparam logic [CNT_W-1:0] VLINES_SXGA  = 11'd1024;
	localparam logic [CNT_W-1:0] VFNPRCH_SXGA = 11'd1;
	localparam logic [CNT_W-1:0] VSYNCPW_SXGA = 11'd3;
	localparam logic [CNT_W-1:0] VBKPRCH_SXGA = 11'd38;

	// Camera variant of 720p with shorter sync
	localparam logic [CNT_W-1:0] HPIXELS_CAMERA = 11'd1280;
	localparam logic [CNT_W-1:0] HFNPRCH_CAMERA = 11'd110;
	localparam logic [CNT_W-1:0] HSYNCPW_CAMERA = 11'd39;
	localparam logic [CNT_W-1:0] HBKPRCH_CAMERA = 11'd220;
	localparam logic [CNT_W-1:0] VLINES_CAMERA  = 11'd720;
	localparam logic [CNT_W-1:0] VFNPRCH_CAMERA = 11'd4;
	localparam logic [CNT_W-1:0] VSYNCPW_CAMERA = 11'd4;
	localparam logic [CNT_W-1:0] VBKPRCH_CAMERA = 11'd22;

	// Negative sync only for the two legacy PC modes
	function automatic logic sync_negative(input logic [FMT_W-1:0] fmt);
		return (fmt == FMT_VGA) || (fmt == FMT_XGA);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Aux word layout
	////////////////////////////////////////////////////////////////////////////
	localparam int AUX_W      = 24;
	localparam int AUX_COL_HI = 23;  // Start column
	localparam int AUX_COL_LO = 12;
	localparam int AUX_NIB_W  = 4;   // Three nibbles below the column
	localparam int AUX_LEN    = 32;  // ade window in cycles

endpackage

//--- hdl/video_timing.sv
`timescale 1ns/1ps

module video_timing (
	input  logic                      clk50m_bufg,
	input  logic                      RSTBTN,
	input  logic [vid_pkg::FMT_W-1:0] fmt,
	output logic [vid_pkg::CNT_W-1:0] hcount,
	output logic [vid_pkg::CNT_W-1:0] vcount,
	output logic                      active,
	output logic                      hsync_raw,
	output logic                      vsync_raw,
	output logic                      sync_neg
);

	// Raw constants picked by format
	logic [vid_pkg::CNT_W-1:0] sel_hpix, sel_hfp, sel_hsw, sel_hbp;
	logic [vid_pkg::CNT_W-1:0] sel_vlin, sel_vfp, sel_vsw, sel_vbp;

	// Registered limits
	logic [vid_pkg::CNT_W-1:0] h_pix, h_ss, h_se, h_end;
	logic [vid_pkg::CNT_W-1:0] v_lin, v_ss, v_se, v_end;

	////////////////////////////////////////////////////////////////////////////
	// Format decode
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (fmt)
			vid_pkg::FMT_VGA: begin
				sel_hpix = vid_pkg::HPIXELS_VGA;
				sel_hfp  = vid_pkg::HFNPRCH_VGA;
				sel_hsw  = vid_pkg::HSYNCPW_VGA;
				sel_hbp  = vid_pkg::HBKPRCH_VGA;
				sel_vlin = vid_pkg::VLINES_VGA;
				sel_vfp  = vid_pkg::VFNPRCH_VGA;
				sel_vsw  = vid_pkg::VSYNCPW_VGA;
				sel_vbp  = vid_pkg::VBKPRCH_VGA;
			end
			vid_pkg::FMT_SVGA: begin
				sel_hpix = vid_pkg::HPIXELS_SVGA;
				sel_hfp  = vid_pkg::HFNPRCH_SVGA;
				sel_hsw  = vid_pkg::HSYNCPW_SVGA;
				sel_hbp  = vid_pkg::HBKPRCH_SVGA;
				sel_vlin = vid_pkg::VLINES_SVGA;
				sel_vfp  = vid_pkg::VFNPRCH_SVGA;
				sel_vsw  = vid_pkg::VSYNCPW_SVGA;
				sel_vbp  = vid_pkg::VBKPRCH_SVGA;
			end
			vid_pkg::FMT_XGA: begin
				sel_hpix = vid_pkg::HPIXELS_XGA;
				sel_hfp  = vid_pkg::HFNPRCH_XGA;
				sel_hsw  = vid_pkg::HSYNCPW_XGA;
				sel_hbp  = vid_pkg::HBKPRCH_XGA;
				sel_vlin = vid_pkg::VLINES_XGA;
				sel_vfp  = vid_pkg::VFNPRCH_XGA;
				sel_vsw  = vid_pkg::VSYNCPW_XGA;
				sel_vbp  = vid_pkg::VBKPRCH_XGA;
			end
			vid_pkg::FMT_SXGA: begin
				sel_hpix = vid_pkg::HPIXELS_SXGA;
				sel_hfp  = vid_pkg::HFNPRCH_SXGA;
				sel_hsw  = vid_pkg::HSYNCPW_SXGA;
				sel_hbp  = vid_pkg::HBKPRCH_SXGA;
				sel_vlin = vid_pkg::VLINES_SXGA;
				sel_vfp  = vid_pkg::VFNPRCH_SXGA;
				sel_vsw  = vid_pkg::VSYNCPW_SXGA;
				sel_vbp  = vid_pkg::VBKPRCH_SXGA;
			end
			vid_pkg::FMT_CAMERA: begin
				sel_hpix = vid_pkg::HPIXELS_CAMERA;
				sel_hfp  = vid_pkg::HFNPRCH_CAMERA;
				sel_hsw  = vid_pkg::HSYNCPW_CAMERA;
				sel_hbp  = vid_pkg::HBKPRCH_CAMERA;
				sel_vlin = vid_pkg::VLINES_CAMERA;
				sel_vfp  = vid_pkg::VFNPRCH_CAMERA;
				sel_vsw  = vid_pkg::VSYNCPW_CAMERA;
				sel_vbp  = vid_pkg::VBKPRCH_CAMERA;
			end
			default: begin // 720p and every unused code
				sel_hpix = vid_pkg::HPIXELS_HDTV720P;
				sel_hfp  = vid_pkg::HFNPRCH_HDTV720P;
				sel_hsw  = vid_pkg::HSYNCPW_HDTV720P;
				sel_hbp  = vid_pkg::HBKPRCH_HDTV720P;
				sel_vlin = vid_pkg::VLINES_HDTV720P;
				sel_vfp  = vid_pkg::VFNPRCH_HDTV720P;
				sel_vsw  = vid_pkg::VSYNCPW_HDTV720P;
				sel_vbp  = vid_pkg::VBKPRCH_HDTV720P;
			end
		endcase
	end

	// Limits and polarity follow fmt on every clock
	always_ff @(posedge clk50m_bufg) begin
		h_pix    <= sel_hpix;
		h_ss     <= sel_hpix + sel_hfp;                       // Sync start column
		h_se     <= sel_hpix + sel_hfp + sel_hsw;             // First column after sync
		h_end    <= sel_hpix + sel_hfp + sel_hsw + sel_hbp - 11'd1;
		v_lin    <= sel_vlin;
		v_ss     <= sel_vlin + sel_vfp;
		v_se     <= sel_vlin + sel_vfp + sel_vsw;
		v_end    <= sel_vlin + sel_vfp + sel_vsw + sel_vbp - 11'd1;
		sync_neg <= vid_pkg::sync_negative(fmt);
	end

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hcount <= '0;
			vcount <= '0;
		end else if (hcount == h_end) begin
			hcount <= '0;                                  // Line wrap
			vcount <= (vcount == v_end) ? '0 : vcount + 11'd1;
		end else begin
			hcount <= hcount + 11'd1;
		end
	end

	// Windows straight from the registers
	assign active    = (hcount < h_pix) && (vcount < v_lin);
	assign hsync_raw = (hcount >= h_ss) && (hcount < h_se);
	assign vsync_raw = (vcount >= v_ss) && (vcount < v_se);

	// Counter stays inside the line and frame of the selected format
	a_line_end: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		(hcount <= h_end) && (vcount <= v_end));

endmodule

//--- hdl/aux_fifo.sv
`timescale 1ns/1ps

module aux_fifo #(
	parameter int AUX_DEPTH = 16
) (
	input  logic                      clk50m_bufg,
	input  logic                      RSTBTN,
	input  logic                      wr,
	input  logic [vid_pkg::AUX_W-1:0] din,
	input  logic                      pop,
	output logic [vid_pkg::AUX_W-1:0] head,
	output logic                      empty,
	output logic                      full
);

	localparam int PTR_W = $clog2(AUX_DEPTH);

	logic [vid_pkg::AUX_W-1:0] mem [AUX_DEPTH];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [PTR_W:0]            cnt;      // Occupancy
	logic [PTR_W:0]            cnt_nxt;
	logic                      do_wr;
	logic                      do_pop;

	assign do_wr  = wr && !full;    // Writes into a full FIFO are lost
	assign do_pop = pop && !empty;

	// Fall-through head
	assign head = mem[rd_ptr];

	always_comb begin
		case ({do_wr, do_pop})
			2'b10:   cnt_nxt = cnt + 1'b1;
			2'b01:   cnt_nxt = cnt - 1'b1;
			default: cnt_nxt = cnt;       // Idle or write plus pop
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	// Pointers wrap on their own for power of two depth
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
			empty  <= 1'b1;
			full   <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			cnt   <= cnt_nxt;
			empty <= (cnt_nxt == '0);
			full  <= (cnt_nxt == (PTR_W+1)'(AUX_DEPTH));
		end
	end

	// Source must respect full
	a_no_wr_full: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!(wr && full));

	// Island scheduler pops only a valid head
	a_no_pop_empty: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!(pop && empty));

endmodule

//--- hdl/aux_island.sv
`timescale 1ns/1ps

module aux_island (
	input  logic                          clk50m_bufg,
	input  logic                          RSTBTN,
	input  logic [vid_pkg::CNT_W-1:0]     hcount,
	input  logic                          active,
	input  logic                          hsync_raw,
	input  logic                          vsync_raw,
	input  logic                          sync_neg,
	input  logic [vid_pkg::AUX_W-1:0]     head,
	input  logic                          empty,
	output logic                          pop,
	output logic                          hsync,
	output logic                          vsync,
	output logic                          vde,
	output logic                          ade,
	output logic [vid_pkg::AUX_NIB_W-1:0] aux0,
	output logic [vid_pkg::AUX_NIB_W-1:0] aux1,
	output logic [vid_pkg::AUX_NIB_W-1:0] aux2
);

	localparam int COL_W = vid_pkg::AUX_COL_HI - vid_pkg::AUX_COL_LO + 1;
	localparam int LEN_W = $clog2(vid_pkg::AUX_LEN);
	localparam int NW    = vid_pkg::AUX_NIB_W;

	logic             hs_q;     // First sync stage
	logic             vs_q;
	logic             act_q;
	logic [COL_W-1:0] col;      // Start column of head word
	logic             start;
	logic             win;      // Internal enable, leads ade by one
	logic [LEN_W-1:0] len_cnt;
	logic [vid_pkg::AUX_COL_LO-1:0] nib_q;

	////////////////////////////////////////////////////////////////////////////
	// Sync and data enable pipeline
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hs_q  <= sync_neg;    // Inactive level of the format
			hsync <= sync_neg;
			vs_q  <= sync_neg;
			vsync <= sync_neg;
			act_q <= 1'b0;
			vde   <= 1'b0;
		end else begin
			hs_q  <= hsync_raw ^ sync_neg;
			hsync <= hs_q;
			vs_q  <= vsync_raw ^ sync_neg;
			vsync <= vs_q;
			act_q <= active;
			vde   <= act_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Aux island scheduling
	////////////////////////////////////////////////////////////////////////////
	assign col = head[vid_pkg::AUX_COL_HI:vid_pkg::AUX_COL_LO];

	// Blanking only, one window at a time
	assign start = !empty && !win && !vde && (col == COL_W'(hcount));
	assign pop   = start;

	// Nibbles of the popped word
	always_ff @(posedge clk50m_bufg) begin
		if (start) begin
			nib_q <= head[vid_pkg::AUX_COL_LO-1:0];
		end
	end

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			win     <= 1'b0;
			len_cnt <= '0;
			ade     <= 1'b0;
			aux0    <= '0;
			aux1    <= '0;
			aux2    <= '0;
		end else begin
			if (start) begin
				win <= 1'b1;
			end else if (win) begin
				if (len_cnt == LEN_W'(vid_pkg::AUX_LEN - 1)) begin
					win     <= 1'b0;    // Window done
					len_cnt <= '0;
				end else begin
					len_cnt <= len_cnt + 1'b1;
				end
			end
			// Output stage
			ade  <= win;
			aux0 <= win ? nib_q[NW-1:0]      : '0;
			aux1 <= win ? nib_q[2*NW-1:NW]   : '0;
			aux2 <= win ? nib_q[3*NW-1:2*NW] : '0;
		end
	end

	// Islands and live video never share a cycle at the output
	a_ade_vde: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		!(ade && vde));

endmodule

//--- hdl/video_tx_top.sv
`timescale 1ns/1ps

module video_tx_top #(
	parameter int AUX_DEPTH = 16
) (
	input  logic                          clk50m_bufg,
	input  logic                          RSTBTN,
	input  logic [vid_pkg::FMT_W-1:0]     fmt,
	input  logic [vid_pkg::AUX_W-1:0]     aux_word,
	input  logic                          aux_wr,
	output logic                          aux_full,
	output logic [vid_pkg::CNT_W-1:0]     hcount,   // Pixel position for a pattern source
	output logic [vid_pkg::CNT_W-1:0]     vcount,
	output logic                          hsync,
	output logic                          vsync,
	output logic                          vde,
	output logic                          ade,
	output logic [vid_pkg::AUX_NIB_W-1:0] aux0,
	output logic [vid_pkg::AUX_NIB_W-1:0] aux1,
	output logic [vid_pkg::AUX_NIB_W-1:0] aux2
);

	logic                      active;
	logic                      hsync_raw;
	logic                      vsync_raw;
	logic                      sync_neg;
	logic [vid_pkg::AUX_W-1:0] head;
	logic                      empty;
	logic                      pop;

	////////////////////////////////////////////////////////////////////////////
	// Timing, aux queue and island scheduler
	////////////////////////////////////////////////////////////////////////////
	video_timing timing0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.fmt         (fmt),
		.hcount      (hcount),
		.vcount      (vcount),
		.active      (active),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.sync_neg    (sync_neg)
	);

	aux_fifo #(.AUX_DEPTH(AUX_DEPTH)) fifo0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.wr          (aux_wr),
		.din         (aux_word),
		.pop         (pop),
		.head        (head),
		.empty       (empty),
		.full        (aux_full)
	);

	aux_island island0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.hcount      (hcount),
		.active      (active),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.sync_neg    (sync_neg),
		.head        (head),
		.empty       (empty),
		.pop         (pop),
		.hsync       (hsync),
		.vsync       (vsync),
		.vde         (vde),
		.ade         (ade),
		.aux0        (aux0),
		.aux1        (aux1),
		.aux2        (aux2)
	);

endmodule

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// Reference timing
////////////////////////////////////////////////////////////////////////////
// Fields packed as {hpix, hfp, hsw, hbp, vlin, vfp, vsw, vbp}
function automatic logic [8*vid_pkg::CNT_W-1:0] fmt_timing(input logic [vid_pkg::FMT_W-1:0] f);
	case (f)
		4'b0000: return {11'd640, 11'd16, 11'd96, 11'd48, 11'd480, 11'd11, 11'd2, 11'd31};
		4'b0001: return {11'd800, 11'd40, 11'd128, 11'd88, 11'd600, 11'd1, 11'd4, 11'd23};
		4'b0011: return {11'd1024, 11'd24, 11'd136, 11'd160, 11'd768, 11'd3, 11'd6, 11'd29};
		4'b1000: return {11'd1280, 11'd48, 11'd112, 11'd248, 11'd1024, 11'd1, 11'd3, 11'd38};
		4'b1001: return {11'd1280, 11'd110, 11'd39, 11'd220, 11'd720, 11'd4, 11'd4, 11'd22};
		default: return {11'd1280, 11'd110, 11'd40, 11'd220, 11'd720, 11'd5, 11'd5, 11'd20};
	endcase
endfunction

// Field 0 is hpix, field 7 is vbp
function automatic int timing_field(input logic [vid_pkg::FMT_W-1:0] f, input int idx);
	logic [8*vid_pkg::CNT_W-1:0] t;
	t = fmt_timing(f);
	return t[(7-idx)*vid_pkg::CNT_W +: vid_pkg::CNT_W];
endfunction

function automatic int line_len_of(input logic [vid_pkg::FMT_W-1:0] f);
	return timing_field(f, 0) + timing_field(f, 1) + timing_field(f, 2) + timing_field(f, 3);
endfunction

function automatic int frame_len_of(input logic [vid_pkg::FMT_W-1:0] f);
	return timing_field(f, 4) + timing_field(f, 5) + timing_field(f, 6) + timing_field(f, 7);
endfunction

function automatic logic live_at(input int h, input int v, input logic [vid_pkg::FMT_W-1:0] f);
	return (h < timing_field(f, 0)) && (v < timing_field(f, 4));
endfunction

// VGA and XGA run negative sync
function automatic logic neg_polarity(input logic [vid_pkg::FMT_W-1:0] f);
	return (f == 4'b0000) || (f == 4'b0011);
endfunction

function automatic logic hsync_at(input int h, input logic [vid_pkg::FMT_W-1:0] f);
	int ss;
	ss = timing_field(f, 0) + timing_field(f, 1);    // First sync column
	return neg_polarity(f) ^ ((h >= ss) && (h < ss + timing_field(f, 2)));
endfunction

function automatic logic vsync_at(input int v, input logic [vid_pkg::FMT_W-1:0] f);
	int ss;
	ss = timing_field(f, 4) + timing_field(f, 5);    // First sync line
	return neg_polarity(f) ^ ((v >= ss) && (v < ss + timing_field(f, 6)));
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////
task automatic level_check(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic count_check(input string what, input logic [vid_pkg::CNT_W-1:0] got,
		input logic [vid_pkg::CNT_W-1:0] exp);
	if (got !== exp) begin
		$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic nibble_check(input logic [vid_pkg::AUX_NIB_W-1:0] got0, got1, got2,
		input logic [vid_pkg::AUX_NIB_W-1:0] exp0, exp1, exp2);
	if ({got0, got1, got2} !== {exp0, exp1, exp2}) begin
		$display("Mismatch at %0t: aux nibbles %h %h %h, expected %h %h %h", $time,
			got0, got1, got2, exp0, exp1, exp2);
		abort_run();
	end
endtask

`endif

//--- bench/tb_video_tx.sv
`timescale 1ns/1ps

module tb_video_tx;

	localparam int AUX_DEPTH = 16;
	localparam int AUX_WORDS = 6;    // Ordered island test
	localparam int FMT_LINES = 3;    // Lines per short format run
	// VGA frame, about a VGA line per aux word, short runs of the longest line
	localparam int TIMEOUT_CYCLES = 800 * 525 + (AUX_WORDS + AUX_DEPTH + 8) * 800
		+ 6 * (FMT_LINES + 1) * 1688 + 1000;

	logic                          clk50m_bufg;
	logic                          RSTBTN;
	logic [vid_pkg::FMT_W-1:0]     fmt;
	logic [vid_pkg::AUX_W-1:0]     aux_word;
	logic                          aux_wr;
	logic                          aux_full;
	logic [vid_pkg::CNT_W-1:0]     hcount;
	logic [vid_pkg::CNT_W-1:0]     vcount;
	logic                          hsync;
	logic                          vsync;
	logic                          vde;
	logic                          ade;
	logic [vid_pkg::AUX_NIB_W-1:0] aux0;
	logic [vid_pkg::AUX_NIB_W-1:0] aux1;
	logic [vid_pkg::AUX_NIB_W-1:0] aux2;

	integer seed = 32'h84af;
	int cycles = 0;
	int n_since = 0;    // Cycles since reset release
	int age = 1000;     // Cycles since last island start
	int written = 0;
	int served = 0;
	logic [vid_pkg::CNT_W-1:0] h_hist [2];
	logic [vid_pkg::CNT_W-1:0] v_hist [2];
	logic [vid_pkg::CNT_W-1:0] exp_h;
	logic [vid_pkg::CNT_W-1:0] exp_v;
	logic [vid_pkg::AUX_W-1:0] aux_q [$];    // Model of FIFO contents
	logic [vid_pkg::AUX_W-1:0] popped;
	logic [11:0]               exp_nib;
	logic                      exp_vde;
	logic                      exp_ade;
	logic                      exp_full;
	logic                      prev_ade = 1'b0;
	logic [vid_pkg::FMT_W-1:0] fmt_list [6] = '{vid_pkg::FMT_SVGA, vid_pkg::FMT_XGA,
		vid_pkg::FMT_HDTV720P, vid_pkg::FMT_SXGA, vid_pkg::FMT_CAMERA, 4'b0111};

	video_tx_top #(.AUX_DEPTH(AUX_DEPTH)) dut0 (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.fmt         (fmt),
		.aux_word    (aux_word),
		.aux_wr      (aux_wr),
		.aux_full    (aux_full),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.vde         (vde),
		.ade         (ade),
		.aux0        (aux0),
		.aux1        (aux1),
		.aux2        (aux2)
	);

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1);
	endtask

	`include "tb_checks.svh"

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;
	end

	always @(posedge clk50m_bufg) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	// fmt only moves while reset is held
	task automatic reset_into(input logic [vid_pkg::FMT_W-1:0] f);
		RSTBTN <= 1'b1;
		fmt    <= f;
		repeat (4) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
	endtask

	task automatic wait_for_line(input int n);
		do @(negedge clk50m_bufg); while (vcount != n);
		@(posedge clk50m_bufg);
	endtask

	// Column past the vde tail so the window ends by the line end
	task automatic write_aux_word();
		int lo;
		int span;
		lo   = timing_field(fmt, 0) + 2;
		span = line_len_of(fmt) - vid_pkg::AUX_LEN - lo;
		aux_word <= {12'(lo + $unsigned($random(seed)) % span), 12'($random(seed))};
		aux_wr   <= 1'b1;
		written++;
		@(posedge clk50m_bufg);
	endtask

	task automatic drain_islands();
		while (served != written) @(posedge clk50m_bufg);
	endtask

	initial begin
		RSTBTN   = 1'b1;
		fmt      = vid_pkg::FMT_VGA;
		aux_word = '0;
		aux_wr   = 1'b0;
		reset_into(vid_pkg::FMT_VGA);
		wait_for_line(frame_len_of(vid_pkg::FMT_VGA) - 1);    // Whole VGA frame and wrap
		wait_for_line(0);
		wait_for_line(1);
		repeat (AUX_WORDS) write_aux_word();    // Ordered islands
		aux_wr <= 1'b0;
		drain_islands();
		// Fill at line start long before any column
		do @(negedge clk50m_bufg); while (hcount != 0);
		@(posedge clk50m_bufg);
		repeat (AUX_DEPTH) write_aux_word();
		aux_wr <= 1'b0;
		@(negedge clk50m_bufg);
		level_check("aux_full after fill", aux_full, 1'b1);
		@(posedge clk50m_bufg);
		drain_islands();
		foreach (fmt_list[i]) begin
			reset_into(fmt_list[i]);
			wait_for_line(FMT_LINES);
		end
		$display("Test OK");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare process sampling on the falling edge
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk50m_bufg) begin
		if (RSTBTN) begin
			n_since  = 0;
			age      = 1000;
			prev_ade = 1'b0;
			aux_q.delete();
		end else begin
			n_since++;
			if (n_since == 1) begin    // Counters fresh out of reset
				exp_h = '0;
				exp_v = '0;
			end else if (exp_h == line_len_of(fmt) - 1) begin
				exp_h = '0;
				exp_v = (exp_v == frame_len_of(fmt) - 1) ? '0 : exp_v + 1'b1;
			end else begin
				exp_h = exp_h + 1'b1;
			end
			count_check("hcount", hcount, exp_h);
			count_check("vcount", vcount, exp_v);
			// Reset levels until two post-reset samples exist
			exp_vde = (n_since >= 3) && live_at(h_hist[1], v_hist[1], fmt);
			level_check("vde", vde, exp_vde);
			level_check("hsync", hsync,
				(n_since >= 3) ? hsync_at(h_hist[1], fmt) : neg_polarity(fmt));
			level_check("vsync", vsync,
				(n_since >= 3) ? vsync_at(v_hist[1], fmt) : neg_polarity(fmt));

			// Island model
			if (age < 1000) age++;
			exp_full = (aux_q.size() == AUX_DEPTH);
			exp_ade  = (age >= 2) && (age <= vid_pkg::AUX_LEN + 1);
			level_check("aux_full", aux_full, exp_full);
			level_check("ade", ade, exp_ade);
			nibble_check(aux0, aux1, aux2, exp_ade ? exp_nib[3:0] : 4'h0,
				exp_ade ? exp_nib[7:4] : 4'h0, exp_ade ? exp_nib[11:8] : 4'h0);
			if (aux_q.size() != 0 && !(age >= 1 && age <= vid_pkg::AUX_LEN) && !exp_vde
					&& aux_q[0][vid_pkg::AUX_COL_HI:vid_pkg::AUX_COL_LO] == 12'(exp_h)) begin
				popped  = aux_q.pop_front();    // Start pops the model head
				exp_nib = popped[11:0];
				age     = 0;
			end
			if (aux_wr && !exp_full) aux_q.push_back(aux_word);    // Visible next cycle
			if (prev_ade && !ade) served++;
			prev_ade  = ade;
		end
		h_hist[1] = h_hist[0];
		h_hist[0] = hcount;
		v_hist[1] = v_hist[0];
		v_hist[0] = vcount;
	end

endmodule

//--- src.f
+incdir+bench
hdl/vid_pkg.sv
hdl/video_timing.sv
hdl/aux_fifo.sv
hdl/aux_island.sv
hdl/video_tx_top.sv
bench/tb_video_tx.sv

//--- Bender.yml
package:
  name: video_tx

sources:
  - hdl/vid_pkg.sv
  - hdl/video_timing.sv
  - hdl/aux_fifo.sv
  - hdl/aux_island.sv
  - hdl/video_tx_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_video_tx.sv
